/* baud/uart_baud_gen.sv */
module uart_baud_gen (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  uart_reg_pkg::div_cfg_t div_cfg_i,
  output uart_pkg::ticks_t       ticks_o
);

  logic [15:0]                   divisor;
  logic [15:0]                   os_last;
  logic [15:0]                   os_cnt;
  logic                          os_wrap;
  logic                          os_tick;
  logic [uart_pkg::OS_CNT_W-1:0] baud_cnt;

  // ------------------------------------------------------------------
  // Oversample counter
  // ------------------------------------------------------------------

  // DLM is the upper byte
  assign divisor = {div_cfg_i.dlm, div_cfg_i.dll};
  // Zero divisor behaves as one
  assign os_last = (divisor == 16'd0) ? 16'd0 : divisor - 16'd1;

  // Terminal count
  assign os_wrap = (os_cnt == os_last);
  // No tick while a new divisor restarts the counters
  assign os_tick = os_wrap & ~div_cfg_i.div_write;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      os_cnt <= '0;
    end else if (div_cfg_i.div_write || os_wrap) begin
      os_cnt <= '0;
    end else begin
      os_cnt <= os_cnt + 16'd1;
    end
  end

  // ------------------------------------------------------------------
  // Baud counter
  // ------------------------------------------------------------------

  // Advances once per oversample tick, wraps after 16
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      baud_cnt <= '0;
    end else if (div_cfg_i.div_write) begin
      baud_cnt <= '0;
    end else if (os_tick) begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Baud tick rides on the oversample tick that wraps the counter
  assign ticks_o.oversample = os_tick;
  assign ticks_o.baud       =
    os_tick & (baud_cnt == uart_pkg::OS_CNT_W'(uart_pkg::OVERSAMPLE - 1));

endmodule

/* common/uart_pkg.sv */
package uart_pkg;

  // ------------------------------------------------------------------
  // Line-side constants
  // ------------------------------------------------------------------

  // Oversample ticks per bit period
  localparam int OVERSAMPLE = 16;
  // Width of any counter that walks one bit period
  localparam int OS_CNT_W = $clog2(OVERSAMPLE);
  // Payload bits per frame
  localparam int DATA_BITS = 8;
  // Start, data and stop bits of an 8N1 frame
  localparam int FRAME_BITS = DATA_BITS + 2;

  // ------------------------------------------------------------------
  // Line-side types
  // ------------------------------------------------------------------

  // Single-cycle strobes from the baud generator
  typedef struct packed {
    logic oversample;
    logic baud;
  } ticks_t;

  // Byte handed to the serializer
  typedef struct packed {
    logic                 valid;
    logic [DATA_BITS-1:0] data;
  } tx_req_t;

  // Byte recovered by the deserializer
  typedef struct packed {
    logic                 valid;
    logic [DATA_BITS-1:0] data;
    logic                 framing_err;
  } rx_byte_t;

endpackage

/* common/uart_reg_pkg.sv */
package uart_reg_pkg;

  // ------------------------------------------------------------------
  // APB bus
  // ------------------------------------------------------------------

  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  // Requester side of the bus
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  // Completer side of the bus
  typedef struct packed {
    logic              pready;
    logic              pslverr;
    logic [APB_DW-1:0] prdata;
  } apb_rsp_t;

  // ------------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------------

  // THR on write, RBR on read
  localparam logic [APB_AW-1:0] ADDR_THR_RBR = 8'h00;
  localparam logic [APB_AW-1:0] ADDR_DLL     = 8'h04;
  localparam logic [APB_AW-1:0] ADDR_DLM     = 8'h08;
  localparam logic [APB_AW-1:0] ADDR_LSR     = 8'h0C;

  // LSR bit positions
  localparam int LSR_DR   = 0;
  localparam int LSR_OE   = 1;
  localparam int LSR_FE   = 3;
  localparam int LSR_TEMT = 5;

  // Divisor bytes plus restart strobe for the baud generator
  typedef struct packed {
    logic [7:0] dll;
    logic [7:0] dlm;
    logic       div_write;
  } div_cfg_t;

  // Stored register state
  typedef struct packed {
    logic [7:0] rbr;
    logic [7:0] dll;
    logic [7:0] dlm;
    logic       dr;
    logic       oe;
    logic       fe;
  } reg_file_t;

endpackage

/* list.f */
common/uart_pkg.sv
common/uart_reg_pkg.sv
logic/uart_apb_regs.sv
baud/uart_baud_gen.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_top.sv
tests/uart_tb.sv

/* logic/uart_apb_regs.sv */
module uart_apb_regs #(
  parameter logic [15:0] DIV_RESET = 16'd1
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  uart_reg_pkg::apb_req_t apb_req_i,
  output uart_reg_pkg::apb_rsp_t apb_rsp_o,
  output uart_reg_pkg::div_cfg_t div_cfg_o,
  output uart_pkg::tx_req_t      tx_req_o,
  input  logic                   tx_busy_i,
  input  uart_pkg::rx_byte_t     rx_byte_i
);

  uart_reg_pkg::reg_file_t regs_q;

  logic       wr_en;
  logic       rd_en;
  logic       sel_thr;
  logic       sel_dll;
  logic       sel_dlm;
  logic       sel_lsr;
  logic       addr_hit;
  logic       temt;
  logic       busy_err;
  logic [7:0] lsr;
  logic [7:0] rd_data;

  // ------------------------------------------------------------------
  // Access decode
  // ------------------------------------------------------------------

  // Access phase only, setup phase is ignored
  assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
  assign rd_en = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;

  assign sel_thr  = (apb_req_i.paddr == uart_reg_pkg::ADDR_THR_RBR);
  assign sel_dll  = (apb_req_i.paddr == uart_reg_pkg::ADDR_DLL);
  assign sel_dlm  = (apb_req_i.paddr == uart_reg_pkg::ADDR_DLM);
  assign sel_lsr  = (apb_req_i.paddr == uart_reg_pkg::ADDR_LSR);
  assign addr_hit = sel_thr | sel_dll | sel_dlm | sel_lsr;

  // Transmitter free, the only back-pressure
  assign temt     = ~tx_busy_i;
  // THR write while a frame is still on the line
  assign busy_err = wr_en & sel_thr & ~temt;

  // ------------------------------------------------------------------
  // Handoff to baud generator and serializer
  // ------------------------------------------------------------------

  assign div_cfg_o.dll       = regs_q.dll;
  assign div_cfg_o.dlm       = regs_q.dlm;
  // Restart strobe on either divisor byte
  assign div_cfg_o.div_write = wr_en & (sel_dll | sel_dlm);

  // Serializer latches at the end of the access cycle
  assign tx_req_o.valid = wr_en & sel_thr & temt;
  assign tx_req_o.data  = apb_req_i.pwdata[7:0];

  // ------------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------------

  always_comb begin
    lsr                         = '0;
    lsr[uart_reg_pkg::LSR_DR]   = regs_q.dr;
    lsr[uart_reg_pkg::LSR_OE]   = regs_q.oe;
    lsr[uart_reg_pkg::LSR_FE]   = regs_q.fe;
    lsr[uart_reg_pkg::LSR_TEMT] = temt;
  end

  always_comb begin
    rd_data = '0;
    if (sel_thr) rd_data = regs_q.rbr;
    if (sel_dll) rd_data = regs_q.dll;
    if (sel_dlm) rd_data = regs_q.dlm;
    if (sel_lsr) rd_data = lsr;
  end

  // Zero wait states
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = ((wr_en | rd_en) & ~addr_hit) | busy_err;
  assign apb_rsp_o.prdata  = rd_en ? {24'b0, rd_data} : '0;

  // ------------------------------------------------------------------
  // Register file
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      regs_q.rbr <= '0;
      regs_q.dll <= DIV_RESET[7:0];
      regs_q.dlm <= DIV_RESET[15:8];
      regs_q.dr  <= 1'b0;
      regs_q.oe  <= 1'b0;
      regs_q.fe  <= 1'b0;
    end else begin
      if (wr_en && sel_dll) regs_q.dll <= apb_req_i.pwdata[7:0];
      if (wr_en && sel_dlm) regs_q.dlm <= apb_req_i.pwdata[7:0];
      // Read side effects
      if (rd_en && sel_thr) regs_q.dr <= 1'b0;
      if (rd_en && sel_lsr) begin
        regs_q.oe <= 1'b0;
        regs_q.fe <= 1'b0;
      end
      // New byte wins over a clear in the same cycle
      if (rx_byte_i.valid) begin
        regs_q.rbr <= rx_byte_i.data;
        regs_q.dr  <= 1'b1;
        regs_q.fe  <= rx_byte_i.framing_err;
        // Unread byte gets overwritten
        if (regs_q.dr && !(rd_en && sel_thr)) regs_q.oe <= 1'b1;
      end
    end
  end

endmodule

/* logic/uart_rx.sv */
module uart_rx (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  uart_pkg::ticks_t   ticks_i,
  input  logic               rx_i,
  output uart_pkg::rx_byte_t rx_byte_o
);

  localparam int W = uart_pkg::OS_CNT_W;
  // Eighth tick lands mid start bit
  localparam logic [W-1:0] MID_LAST = W'(uart_pkg::OVERSAMPLE / 2 - 1);
  localparam logic [W-1:0] BIT_LAST = W'(uart_pkg::OVERSAMPLE - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } rx_state_e;

  rx_state_e                      state;
  logic                           rx_meta;
  logic                           rx_sync;
  logic                           rx_prev;
  logic                           fall;
  logic [W-1:0]                   phase;
  logic [2:0]                     bit_cnt;
  logic [uart_pkg::DATA_BITS-1:0] data_q;
  logic                           valid_q;
  logic                           fe_q;
  logic                           sample;

  // ------------------------------------------------------------------
  // Synchronizer and start edge
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev & ~rx_sync;

  // Bit center reached in data state
  assign sample = ticks_i.oversample && (phase == BIT_LAST) &&
                  (state == ST_DATA);

  // LSB arrives first
  always_ff @(posedge clk_i) begin
    if (sample) data_q <= {rx_sync, data_q[uart_pkg::DATA_BITS-1:1]};
  end

  // ------------------------------------------------------------------
  // Frame FSM
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state   <= ST_IDLE;
      phase   <= '0;
      bit_cnt <= '0;
      valid_q <= 1'b0;
      fe_q    <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          phase <= '0;
          if (fall) state <= ST_START;
        end
        ST_START: if (ticks_i.oversample) begin
          phase <= phase + 1'b1;
          if (phase == MID_LAST) begin
            // Glitch shorter than half a bit goes back to idle
            phase   <= '0;
            bit_cnt <= '0;
            state   <= rx_sync ? ST_IDLE : ST_DATA;
          end
        end
        ST_DATA: if (ticks_i.oversample) begin
          phase <= phase + 1'b1;
          if (phase == BIT_LAST) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'(uart_pkg::DATA_BITS - 1)) state <= ST_STOP;
          end
        end
        default: if (ticks_i.oversample) begin
          phase <= phase + 1'b1;
          if (phase == BIT_LAST) begin
            // Stop bit must be high
            valid_q <= 1'b1;
            fe_q    <= ~rx_sync;
            state   <= ST_IDLE;
          end
        end
      endcase
    end
  end

  assign rx_byte_o.valid       = valid_q;
  assign rx_byte_o.data        = data_q;
  assign rx_byte_o.framing_err = fe_q;

endmodule

/* logic/uart_top.sv */
module uart_top #(
  parameter logic [15:0] DIV_RESET = 16'd1
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  uart_reg_pkg::apb_req_t apb_req_i,
  output uart_reg_pkg::apb_rsp_t apb_rsp_o,
  output logic                   tx_o,
  input  logic                   rx_i
);

  // ------------------------------------------------------------------
  // Stage interconnect
  // ------------------------------------------------------------------

  uart_reg_pkg::div_cfg_t div_cfg;
  uart_pkg::ticks_t       ticks;
  uart_pkg::tx_req_t      tx_req;
  uart_pkg::rx_byte_t     rx_byte;
  logic                   tx_busy;

  // Register block, owns the reset divisor
  uart_apb_regs #(
    .DIV_RESET (DIV_RESET)
  ) u_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .div_cfg_o (div_cfg),
    .tx_req_o  (tx_req),
    .tx_busy_i (tx_busy),
    .rx_byte_i (rx_byte)
  );

  // Shared tick source for both directions
  uart_baud_gen u_baud (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .div_cfg_i (div_cfg),
    .ticks_o   (ticks)
  );

  uart_tx u_tx (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ticks_i   (ticks),
    .tx_req_i  (tx_req),
    .tx_busy_o (tx_busy),
    .tx_o      (tx_o)
  );

  uart_rx u_rx (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ticks_i   (ticks),
    .rx_i      (rx_i),
    .rx_byte_o (rx_byte)
  );

endmodule

/* logic/uart_tx.sv */
module uart_tx (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  uart_pkg::ticks_t   ticks_i,
  input  uart_pkg::tx_req_t  tx_req_i,
  output logic               tx_busy_o,
  output logic               tx_o
);

  localparam int CNT_W = $clog2(uart_pkg::FRAME_BITS + 1);

  logic [uart_pkg::FRAME_BITS-1:0] shreg;
  logic [CNT_W-1:0]                bit_cnt;
  logic                            busy_q;
  logic                            tx_q;
  logic                            load;
  logic                            step;

  // New byte only accepted while idle
  assign load = tx_req_i.valid & ~busy_q;
  // One bit per baud tick once a frame is pending
  assign step = ticks_i.baud & busy_q;

  // ------------------------------------------------------------------
  // Frame shift register
  // ------------------------------------------------------------------

  // Stop, data, start with the start bit in the LSB
  always_ff @(posedge clk_i) begin
    if (load) begin
      shreg <= {1'b1, tx_req_i.data, 1'b0};
    end else if (step) begin
      // Back-fill with idle level
      shreg <= {1'b1, shreg[uart_pkg::FRAME_BITS-1:1]};
    end
  end

  // ------------------------------------------------------------------
  // Bit sequencing
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      tx_q    <= 1'b1;
      bit_cnt <= '0;
    end else if (load) begin
      // Line stays idle until the next baud tick
      busy_q  <= 1'b1;
      bit_cnt <= '0;
    end else if (step) begin
      if (bit_cnt == CNT_W'(uart_pkg::FRAME_BITS)) begin
        // Stop bit has run its full period
        busy_q <= 1'b0;
        tx_q   <= 1'b1;
      end else begin
        tx_q    <= shreg[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign tx_busy_o = busy_q;
  assign tx_o      = tx_q;

endmodule

/* tests/uart_tb.sv */
module uart_tb;

  // Reset divisor with both bytes nonzero
  localparam logic [15:0] DIV_RESET = 16'h0105;
  // Divisor used for all line traffic
  localparam int DIV = 3;
  localparam int FRAMES = 12;
  localparam int POLL_LIMIT = 16 * DIV * 10;
  // Frames x bits x ticks x divisor x period, doubled, plus margin
  localparam int WATCHDOG_T = FRAMES * 10 * 16 * DIV * 100 * 2 + 100_000;

  logic                   clk;
  logic                   rst_n;
  uart_reg_pkg::apb_req_t apb_req;
  uart_reg_pkg::apb_rsp_t apb_rsp;
  logic                   tx;
  logic                   rx;
  logic                   rx_drv;
  logic                   use_loop;

  // Reference model state for LSR
  logic m_dr;
  logic m_oe;
  logic m_fe;

  // Pending checks, drained by the checker
  string       name_q[$];
  logic [31:0] got_q[$];
  logic [31:0] exp_q[$];
  string       c_name;
  logic [31:0] c_got;
  logic [31:0] c_exp;

  integer      seed = 32'h550d1bc8;
  logic [31:0] rnd;
  int          err_cnt = 0;
  int          err_mark = 0;
  int          chk_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  uart_top #(
    .DIV_RESET (DIV_RESET)
  ) u_dut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .tx_o      (tx),
    .rx_i      (rx)
  );

  // External loopback or tb-driven line
  assign rx = use_loop ? tx : rx_drv;

  always #50 clk = ~clk;

  // ----------------------------------------------------------------------
  // Reference model and checker
  // ----------------------------------------------------------------------

  // Expected LSR from the DR, OE, FE and TEMT flags
  function automatic logic [7:0] ref_lsr(input logic dr, input logic oe,
                                         input logic fe, input logic temt);
    logic [7:0] v;
    v    = 8'h00;
    v[0] = dr;
    v[1] = oe;
    v[3] = fe;
    v[5] = temt;
    return v;
  endfunction

  always @(negedge clk) begin
    while (got_q.size() > 0) begin
      c_name = name_q.pop_front();
      c_got  = got_q.pop_front();
      c_exp  = exp_q.pop_front();
      chk_cnt++;
      assert (c_got === c_exp) else begin
        $display("CHECK FAILED t=%0t signal=%s got=0x%0h expected=0x%0h",
                 $time, c_name, c_got, c_exp);
        err_cnt++;
      end
    end
  end

  task automatic queue_check(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  // ----------------------------------------------------------------------
  // APB driver
  // ----------------------------------------------------------------------

  // Setup, access, then idle; response sampled mid access cycle
  task automatic apb_access(input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // Zero wait states on every access
    queue_check("pready", apb_rsp.pready, 1'b1);
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    queue_check("pslverr", err, exp_err);
  endtask

  task automatic read_check(input logic [7:0] addr, input string name,
                            input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, 32'h0, rdata, err);
    queue_check(name, rdata, exp);
  endtask

  // LSR read clears OE and FE
  task automatic check_lsr();
    read_check(uart_reg_pkg::ADDR_LSR, "LSR", ref_lsr(m_dr, m_oe, m_fe, 1'b1));
    m_oe = 1'b0;
    m_fe = 1'b0;
  endtask

  task automatic check_rbr(input logic [7:0] exp);
    read_check(uart_reg_pkg::ADDR_THR_RBR, "RBR", exp);
    m_dr = 1'b0;
  endtask

  task automatic model_rx_frame(input logic fe);
    if (m_dr) m_oe = 1'b1;
    m_dr = 1'b1;
    m_fe = fe;
  endtask

  // Poll LSR until the transmitter is empty
  task automatic wait_temt();
    logic [31:0] rdata;
    logic        err;
    int          polls;
    polls = 0;
    rdata = '0;
    while (!rdata[5] && polls < POLL_LIMIT) begin
      apb_access(1'b0, uart_reg_pkg::ADDR_LSR, 32'h0, rdata, err);
      polls++;
    end
    assert (rdata[5]) else begin
      $display("ERROR at %0t: TEMT stayed low for %0d LSR polls", $time, polls);
      err_cnt++;
    end
    m_oe = 1'b0;
    m_fe = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Line side
  // ----------------------------------------------------------------------

  // Bit-banged 8N1 frame, stop level selectable
  task automatic send_serial(input logic [7:0] data, input logic stop);
    logic [9:0] frame;
    frame = {stop, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rx_drv <= frame[i];
      repeat (16 * DIV - 1) @(posedge clk);
    end
    @(posedge clk);
    rx_drv <= 1'b1;
  endtask

  // Start bit length, then each later bit at its center; data LSB must be 1
  task automatic measure_frame(input logic [7:0] data);
    logic [9:0] frame;
    int         n;
    int         low_len;
    frame = {1'b1, data, 1'b0};
    n     = 0;
    while (tx !== 1'b0 && n < 32 * DIV) begin
      @(negedge clk);
      n++;
    end
    assert (tx === 1'b0) else begin
      $display("ERROR at %0t: no start bit appeared on tx_o after THR write", $time);
      err_cnt++;
    end
    low_len = 0;
    while (tx === 1'b0 && low_len < 32 * DIV) begin
      @(negedge clk);
      low_len++;
    end
    queue_check("start_bit_cycles", low_len, 16 * DIV);
    repeat (8 * DIV) @(negedge clk);
    for (int i = 1; i < 10; i++) begin
      queue_check($sformatf("tx_o bit %0d", i), tx, frame[i]);
      if (i < 9) repeat (16 * DIV) @(negedge clk);
    end
  endtask

  task automatic end_test(input string name);
    while (got_q.size() > 0) @(posedge clk);
    @(posedge clk);
    if (err_cnt == err_mark) begin
      pass_cnt++;
      $display("[%0t] test %s passed", $time, name);
    end else begin
      fail_cnt++;
      $display("[%0t] test %s failed, %0d errors", $time, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  initial begin
    logic [31:0] rd;
    logic        err;
    logic [7:0]  b;
    logic [7:0]  b2;
    clk      = 1'b0;
    rst_n    = 1'b0;
    apb_req  = '0;
    rx_drv   = 1'b1;
    use_loop = 1'b1;
    m_dr     = 1'b0;
    m_oe     = 1'b0;
    m_fe     = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values and divisor readback
    check_lsr();
    read_check(uart_reg_pkg::ADDR_DLL, "DLL", DIV_RESET[7:0]);
    read_check(uart_reg_pkg::ADDR_DLM, "DLM", DIV_RESET[15:8]);
    apb_write(uart_reg_pkg::ADDR_DLL, 32'h34, 1'b0);
    apb_write(uart_reg_pkg::ADDR_DLM, 32'h12, 1'b0);
    read_check(uart_reg_pkg::ADDR_DLL, "DLL", 32'h34);
    read_check(uart_reg_pkg::ADDR_DLM, "DLM", 32'h12);
    apb_write(uart_reg_pkg::ADDR_DLL, DIV, 1'b0);
    apb_write(uart_reg_pkg::ADDR_DLM, 32'h0, 1'b0);
    read_check(uart_reg_pkg::ADDR_DLL, "DLL", DIV);
    end_test("reset_and_divisor");

    // Loopback of random bytes
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      b   = rnd[7:0];
      wait_temt();
      apb_write(uart_reg_pkg::ADDR_THR_RBR, b, 1'b0);
      wait_temt();
      model_rx_frame(1'b0);
      check_lsr();
      check_rbr(b);
      check_lsr();
    end
    end_test("loopback");

    // Bit timing on tx_o
    rnd = $random(seed);
    b   = rnd[7:0] | 8'h01;
    apb_write(uart_reg_pkg::ADDR_THR_RBR, b, 1'b0);
    measure_frame(b);
    wait_temt();
    model_rx_frame(1'b0);
    check_rbr(b);
    check_lsr();
    end_test("bit_timing");

    // Two frames without an RBR read
    use_loop <= 1'b0;
    rnd = $random(seed);
    b   = rnd[7:0];
    rnd = $random(seed);
    b2  = rnd[7:0];
    // Second byte must differ so the overwrite shows
    if (b2 == b) b2 = ~b;
    send_serial(b, 1'b1);
    model_rx_frame(1'b0);
    send_serial(b2, 1'b1);
    model_rx_frame(1'b0);
    check_lsr();
    check_rbr(b2);
    check_lsr();
    end_test("overrun");

    // Bad stop bit, busy THR write, unmapped address
    rnd = $random(seed);
    send_serial(rnd[7:0], 1'b0);
    model_rx_frame(1'b1);
    check_lsr();
    check_rbr(rnd[7:0]);
    use_loop <= 1'b1;
    rnd = $random(seed);
    b   = rnd[7:0];
    b2  = ~b;
    apb_write(uart_reg_pkg::ADDR_THR_RBR, b, 1'b0);
    apb_write(uart_reg_pkg::ADDR_THR_RBR, b2, 1'b1);
    apb_access(1'b0, 8'h10, 32'h0, rd, err);
    queue_check("pslverr", err, 1'b1);
    wait_temt();
    model_rx_frame(1'b0);
    check_lsr();
    check_rbr(b);
    end_test("errors");

    $display("tests passed=%0d failed=%0d, checks=%0d errors=%0d",
             pass_cnt, fail_cnt, chk_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Hang guard
  initial begin
    #(WATCHDOG_T);
    $display("ERROR: watchdog expired, the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

endmodule
